// File: Bender.yml
package:
  name: frontend_top

sources:
  - hdl/rv_decode_pkg.sv
  - hdl/inst_if.sv
  - hdl/ifu.sv
  - hdl/idu.sv
  - hdl/frontend_top.sv
  - target: test
    files:
      - test/tb_frontend.sv

// File: frontend_top.f
hdl/rv_decode_pkg.sv
hdl/inst_if.sv
hdl/ifu.sv
hdl/idu.sv
hdl/frontend_top.sv
test/tb_frontend.sv

// File: hdl/frontend_top.sv
// RV64IM fetch and decode front end
`timescale 1ns/10ps
`default_nettype none

module frontend_top import rv_decode_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000  // boot address
) (
    input  logic            clk,
    input  logic            rst,
    // instruction memory, four-phase
    output logic            mem_req,
    output logic [XLEN-1:0] mem_addr,
    input  logic            mem_ack,
    input  logic [ILEN-1:0] mem_rdata,
    // decoded record
    output logic            dec_valid,
    input  logic            dec_ready,
    output logic [XLEN-1:0] dec_pc,
    output op_e             dec_op,
    output logic [4:0]      dec_rd,
    output logic [4:0]      dec_rs1,
    output logic [4:0]      dec_rs2,
    output logic [XLEN-1:0] dec_imm
);

    inst_if i_inst_if ();              // fetch to decode, redirect back

    ifu #(
        .RESET_PC (RESET_PC)
    ) i_ifu (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .fetch     (i_inst_if.fetch)
    );

    idu i_idu (
        .clk       (clk),
        .rst       (rst),
        .decode    (i_inst_if.decode),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pc    (dec_pc),
        .dec_op    (dec_op),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm)
    );

endmodule

`default_nettype wire

// File: hdl/idu.sv
// Instruction decode unit
`timescale 1ns/10ps
`default_nettype none

module idu import rv_decode_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    inst_if.decode          decode,
    output logic            dec_valid,
    input  logic            dec_ready,
    output logic [XLEN-1:0] dec_pc,
    output op_e             dec_op,
    output logic [4:0]      dec_rd,
    output logic [4:0]      dec_rs1,
    output logic [4:0]      dec_rs2,
    output logic [XLEN-1:0] dec_imm
);

    logic [ILEN-1:0] inst;
    logic [16:0]     key;          // funct7, funct3, major opcode
    op_e             op_d;
    fmt_e            fmt_d;
    logic [XLEN-1:0] imm_d;
    logic            accept;

    assign inst = decode.inst;
    assign key  = {inst[31:25], inst[14:12], inst[6:0]};

    always_comb begin
        op_d = OP_ILLEGAL;
        if (inst == 32'h0000_0073) begin
            op_d = OP_ECALL;
        end else if (inst == 32'h0010_0073) begin
            op_d = OP_EBREAK;
        end else if (inst == 32'h3020_0073) begin
            op_d = OP_MRET;
        end else begin
            casez (key)
                17'b???????_000_0000011: op_d = OP_LB;     // loads
                17'b???????_001_0000011: op_d = OP_LH;
                17'b???????_010_0000011: op_d = OP_LW;
                17'b???????_011_0000011: op_d = OP_LD;
                17'b???????_100_0000011: op_d = OP_LBU;
                17'b???????_101_0000011: op_d = OP_LHU;
                17'b???????_110_0000011: op_d = OP_LWU;
                17'b???????_000_0100011: op_d = OP_SB;     // stores
                17'b???????_001_0100011: op_d = OP_SH;
                17'b???????_010_0100011: op_d = OP_SW;
                17'b???????_011_0100011: op_d = OP_SD;
                17'b???????_000_0010011: op_d = OP_ADDI;
                17'b???????_010_0010011: op_d = OP_SLTI;
                17'b???????_011_0010011: op_d = OP_SLTIU;
                17'b???????_100_0010011: op_d = OP_XORI;
                17'b???????_110_0010011: op_d = OP_ORI;
                17'b???????_111_0010011: op_d = OP_ANDI;
                17'b000000?_001_0010011: op_d = OP_SLLI;   // bit 25 is shamt[5]
                17'b000000?_101_0010011: op_d = OP_SRLI;
                17'b010000?_101_0010011: op_d = OP_SRAI;
                17'b???????_000_0011011: op_d = OP_ADDIW;
                17'b0000000_001_0011011: op_d = OP_SLLIW;
                17'b0000000_101_0011011: op_d = OP_SRLIW;
                17'b0100000_101_0011011: op_d = OP_SRAIW;
                17'b0000000_000_0110011: op_d = OP_ADD;
                17'b0100000_000_0110011: op_d = OP_SUB;
                17'b0000000_001_0110011: op_d = OP_SLL;
                17'b0000000_010_0110011: op_d = OP_SLT;
                17'b0000000_011_0110011: op_d = OP_SLTU;
                17'b0000000_100_0110011: op_d = OP_XOR;
                17'b0000000_101_0110011: op_d = OP_SRL;
                17'b0100000_101_0110011: op_d = OP_SRA;
                17'b0000000_110_0110011: op_d = OP_OR;
                17'b0000000_111_0110011: op_d = OP_AND;
                17'b0000001_000_0110011: op_d = OP_MUL;    // mul/div group
                17'b0000001_100_0110011: op_d = OP_DIV;
                17'b0000001_101_0110011: op_d = OP_DIVU;
                17'b0000001_110_0110011: op_d = OP_REM;
                17'b0000001_111_0110011: op_d = OP_REMU;
                17'b0000000_000_0111011: op_d = OP_ADDW;
                17'b0100000_000_0111011: op_d = OP_SUBW;
                17'b0000000_001_0111011: op_d = OP_SLLW;
                17'b0000000_101_0111011: op_d = OP_SRLW;
                17'b0100000_101_0111011: op_d = OP_SRAW;
                17'b0000001_000_0111011: op_d = OP_MULW;
                17'b0000001_100_0111011: op_d = OP_DIVW;
                17'b0000001_101_0111011: op_d = OP_DIVUW;
                17'b0000001_110_0111011: op_d = OP_REMW;
                17'b0000001_111_0111011: op_d = OP_REMUW;
                17'b???????_???_0110111: op_d = OP_LUI;
                17'b???????_???_0010111: op_d = OP_AUIPC;
                17'b???????_???_1101111: op_d = OP_JAL;
                17'b???????_000_1100111: op_d = OP_JALR;
                17'b???????_000_1100011: op_d = OP_BEQ;
                17'b???????_001_1100011: op_d = OP_BNE;
                17'b???????_100_1100011: op_d = OP_BLT;
                17'b???????_101_1100011: op_d = OP_BGE;
                17'b???????_110_1100011: op_d = OP_BLTU;
                17'b???????_111_1100011: op_d = OP_BGEU;
                17'b???????_001_1110011: op_d = OP_CSRRW;  // csr address in imm
                17'b???????_010_1110011: op_d = OP_CSRRS;
                default:                 op_d = OP_ILLEGAL;
            endcase
        end
    end

    // format follows the operation
    always_comb begin
        case (op_d)
            OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
            OP_ADDIW, OP_JALR, OP_CSRRW, OP_CSRRS:             fmt_d = FMT_I;
            OP_SLLI, OP_SRLI, OP_SRAI,
            OP_SLLIW, OP_SRLIW, OP_SRAIW:                      fmt_d = FMT_SH;
            OP_SB, OP_SH, OP_SW, OP_SD:                        fmt_d = FMT_S;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:  fmt_d = FMT_B;
            OP_LUI, OP_AUIPC:                                  fmt_d = FMT_U;
            OP_JAL:                                            fmt_d = FMT_J;
            OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
            OP_SRL, OP_SRA, OP_OR, OP_AND, OP_ADDW, OP_SUBW,
            OP_SLLW, OP_SRLW, OP_SRAW, OP_MUL, OP_DIV, OP_DIVU,
            OP_REM, OP_REMU, OP_MULW, OP_DIVW, OP_DIVUW,
            OP_REMW, OP_REMUW:                                 fmt_d = FMT_R;
            default:                                           fmt_d = FMT_NONE;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (fmt_d)
            FMT_I:   imm_d = {{(XLEN-12){inst[31]}}, inst[31:20]};
            FMT_SH:  imm_d = {{(XLEN-6){1'b0}}, inst[25:20]};
            FMT_S:   imm_d = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
            FMT_B:   imm_d = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                              inst[11:8], 1'b0};
            FMT_U:   imm_d = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
            FMT_J:   imm_d = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                              inst[30:21], 1'b0};
            default: imm_d = '0;               // R, system, illegal
        endcase
    end

    assign decode.ready       = !dec_valid || dec_ready;  // empty or draining
    assign accept             = decode.valid && decode.ready;
    assign decode.redirect    = accept && (op_d == OP_JAL);
    assign decode.redirect_pc = decode.pc + imm_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else if (decode.ready) begin
            dec_valid <= decode.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_pc  <= decode.pc;
            dec_op  <= op_d;
            dec_rd  <= inst[11:7];
            dec_rs1 <= inst[19:15];
            dec_rs2 <= inst[24:20];
            dec_imm <= imm_d;
        end
    end

    // stalled record must not change
    assert property (@(posedge clk) disable iff (rst)
        dec_valid && !dec_ready |=>
            dec_valid && $stable({dec_pc, dec_op, dec_rd, dec_rs1, dec_rs2, dec_imm}))
        else $error("idu: output record changed while stalled");

endmodule

`default_nettype wire

// File: hdl/ifu.sv
// Instruction fetch unit
`timescale 1ns/10ps
`default_nettype none

module ifu import rv_decode_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000
) (
    input  logic            clk,
    input  logic            rst,
    output logic            mem_req,
    output logic [XLEN-1:0] mem_addr,
    input  logic            mem_ack,
    input  logic [ILEN-1:0] mem_rdata,
    inst_if.fetch           fetch
);

    fetch_st_e       state_q;
    fetch_st_e       state_d;
    logic [XLEN-1:0] pc_q;        // pc of held word, or of the next fetch
    logic [XLEN-1:0] addr_q;      // frozen for one bus transaction
    logic [ILEN-1:0] inst_q;      // held word
    logic            full_q;      // word held for decode
    logic            full_d;
    logic            take;        // handshake to decode
    logic            capture;     // first cycle ack seen

    assign take    = fetch.valid && fetch.ready;
    assign capture = (state_q == REQ) && mem_ack;

    always_comb begin
        full_d = full_q;
        if (capture) begin
            full_d = 1'b1;
        end else if (take) begin
            full_d = 1'b0;             // transferred, jal included
        end
    end

    // four-phase bus sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                state_d = REQ;         // only reached with empty hold slot
            end
            REQ: begin
                if (mem_ack) begin
                    state_d = WAIT_RELEASE;
                end
            end
            WAIT_RELEASE: begin
                if (!mem_ack) begin
                    state_d = full_d ? HOLD : IDLE;
                end
            end
            HOLD: begin
                if (!full_d) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
            pc_q    <= RESET_PC;
            full_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            full_q  <= full_d;
            if (fetch.redirect) begin
                pc_q <= fetch.redirect_pc;
            end else if (take) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE) begin
            addr_q <= pc_q;            // address latched as req rises
        end
        if (capture) begin
            inst_q <= mem_rdata;
        end
    end

    assign mem_req     = (state_q == REQ);
    assign mem_addr    = addr_q;
    assign fetch.valid = full_q;
    assign fetch.pc    = pc_q;
    assign fetch.inst  = inst_q;

    // request is held until memory answers
    assert property (@(posedge clk) disable iff (rst)
        $fell(mem_req) |-> $past(mem_ack))
        else $error("ifu: mem_req fell before mem_ack");

    assert property (@(posedge clk) disable iff (rst)
        mem_req && !mem_ack |=> $stable(mem_addr))
        else $error("ifu: mem_addr moved during a request");

endmodule

`default_nettype wire

// File: hdl/inst_if.sv
// Fetch to decode link
`timescale 1ns/10ps
`default_nettype none

interface inst_if import rv_decode_pkg::*; ();

    logic            valid;        // fetched word present
    logic            ready;        // decode can take it
    logic [XLEN-1:0] pc;           // address of inst
    logic [ILEN-1:0] inst;         // raw instruction word
    logic            redirect;     // jal accepted, one cycle
    logic [XLEN-1:0] redirect_pc;  // jump target

    modport fetch (
        output valid, pc, inst,
        input  ready, redirect, redirect_pc
    );

    modport decode (
        input  valid, pc, inst,
        output ready, redirect, redirect_pc
    );

endinterface

`default_nettype wire

// File: hdl/rv_decode_pkg.sv
// RV64IM decode definitions
`default_nettype none

package rv_decode_pkg;

    localparam int XLEN = 64;                 // pc and immediate width
    localparam int ILEN = 32;                 // instruction word width

    // one code per decoded operation
    typedef enum logic [7:0] {
        OP_ILLEGAL,                           // fallback, unknown word
        OP_LB, OP_LH, OP_LW, OP_LD,           // loads
        OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD,           // stores
        OP_ADDI, OP_SLTI, OP_SLTIU,           // immediate alu
        OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,            // immediate shifts, 6-bit shamt
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT,       // register alu
        OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
        OP_OR, OP_AND,
        OP_ADDW, OP_SUBW, OP_SLLW,            // 32-bit word ops
        OP_SRLW, OP_SRAW,
        OP_MUL, OP_DIV, OP_DIVU,              // M extension
        OP_REM, OP_REMU,
        OP_MULW, OP_DIVW, OP_DIVUW,
        OP_REMW, OP_REMUW,
        OP_LUI, OP_AUIPC,                     // upper immediates
        OP_JAL, OP_JALR,                      // jumps
        OP_BEQ, OP_BNE, OP_BLT,               // conditional branches
        OP_BGE, OP_BLTU, OP_BGEU,
        OP_CSRRW, OP_CSRRS,                   // csr access
        OP_ECALL, OP_EBREAK, OP_MRET          // system
    } op_e;

    // immediate layout selector
    typedef enum logic [2:0] {
        FMT_R,                                // no immediate
        FMT_I,
        FMT_SH,                               // shift amount only
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE                              // system and illegal
    } fmt_e;

    // fetch bus phases
    typedef enum logic [1:0] {
        IDLE,                                 // bus released, about to request
        REQ,                                  // mem_req high, waiting for ack
        WAIT_RELEASE,                         // req dropped, waiting for ack low
        HOLD                                  // bus idle, word waiting for decode
    } fetch_st_e;

endpackage

`default_nettype wire

// File: test/tb_frontend.sv
// Front end directed testbench
`timescale 1ns/10ps
`default_nettype none

module tb_frontend import rv_decode_pkg::*; ();

    localparam logic [XLEN-1:0] RESET_PC   = 64'h0000_0000_8000_0000;
    localparam int              MAX_CYCLES = 4000;   // about 1000 needed by all tests

    logic            clk;
    logic            rst;
    logic            mem_req;
    logic [XLEN-1:0] mem_addr;
    logic            mem_ack;
    logic [ILEN-1:0] mem_rdata;
    logic            dec_valid;
    logic            dec_ready;
    logic [XLEN-1:0] dec_pc;
    op_e             dec_op;
    logic [4:0]      dec_rd;
    logic [4:0]      dec_rs1;
    logic [4:0]      dec_rs2;
    logic [XLEN-1:0] dec_imm;

    logic [ILEN-1:0] mem  [0:1023];    // words from RESET_PC on
    logic [ILEN-1:0] prog [0:1023];    // next program, copied in during reset
    logic [9:0]      mem_idx;
    int unsigned     ack_wait;         // cycles left before ack
    int unsigned     stall_cnt;
    logic            stall_en;         // random dec_ready
    logic            collecting;
    logic            stalled_q;        // record was held last edge
    logic [150:0]    rec_now;
    logic [150:0]    snap;
    logic [XLEN-1:0] got_pc [$];
    logic [7:0]      got_op [$];
    logic [4:0]      got_rd [$];
    logic [4:0]      got_rs1 [$];
    logic [4:0]      got_rs2 [$];
    logic [XLEN-1:0] got_imm [$];
    int              exp_idx [$];      // expected word order
    string           test_name;
    int              errors;
    int              err_start;
    int              n_pass;
    int              n_fail;
    int              cycles;

    // op tables by funct3
    op_e load_op [8]  = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU, OP_ILLEGAL};
    op_e store_op [8] = '{OP_SB, OP_SH, OP_SW, OP_SD, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL,
                          OP_ILLEGAL};
    op_e imm_op [8]   = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI, OP_SRLI, OP_ORI,
                          OP_ANDI};
    op_e reg_op [8]   = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
    op_e mul_op [8]   = '{OP_MUL, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL, OP_DIV, OP_DIVU,
                          OP_REM, OP_REMU};
    op_e mulw_op [8]  = '{OP_MULW, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL, OP_DIVW, OP_DIVUW,
                          OP_REMW, OP_REMUW};
    op_e regw_op [8]  = '{OP_ADDW, OP_SLLW, OP_ILLEGAL, OP_ILLEGAL, OP_ILLEGAL, OP_SRLW,
                          OP_ILLEGAL, OP_ILLEGAL};

    frontend_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pc    (dec_pc),
        .dec_op    (dec_op),
        .dec_rd    (dec_rd),
        .dec_rs1   (dec_rs1),
        .dec_rs2   (dec_rs2),
        .dec_imm   (dec_imm)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;              // 4 ns period
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run aborted, still busy after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // memory slave, random ack delay
    assign mem_idx = 10'((mem_addr - RESET_PC) >> 2);

    always @(posedge clk) begin
        if (rst) begin
            mem_ack  <= 1'b0;
            ack_wait <= $urandom % 4;
        end else if (mem_req && !mem_ack) begin
            if (ack_wait == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem[mem_idx];
            end else begin
                ack_wait <= ack_wait - 1;
            end
        end else if (!mem_req && mem_ack) begin
            mem_ack  <= 1'b0;                // release once req is gone
            ack_wait <= $urandom % 4;
        end
    end

    always @(posedge clk) begin
        if (!stall_en) begin
            dec_ready <= 1'b1;
        end else if (stall_cnt != 0) begin
            dec_ready <= 1'b0;
            stall_cnt <= stall_cnt - 1;
        end else if ($urandom % 3 == 0) begin
            dec_ready <= 1'b0;
            stall_cnt <= $urandom % 6;        // length of this stretch
        end else begin
            dec_ready <= 1'b1;
        end
    end

    // output monitor and stall stability
    assign rec_now = {dec_pc, dec_op, dec_rd, dec_rs1, dec_rs2, dec_imm};

    always @(posedge clk) begin
        if (rst) begin
            stalled_q <= 1'b0;
        end else begin
            if (stalled_q && rec_now !== snap) begin
                errors++;
                $display("FAIL %s record expected %h actual %h", test_name, snap, rec_now);
            end
            stalled_q <= dec_valid && !dec_ready;
            snap      <= rec_now;
            if (collecting && dec_valid && dec_ready) begin
                got_pc.push_back(dec_pc);
                got_op.push_back(dec_op);
                got_rd.push_back(dec_rd);
                got_rs1.push_back(dec_rs1);
                got_rs2.push_back(dec_rs2);
                got_imm.push_back(dec_imm);
            end
        end
    end

    function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                          logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2,
                                          logic [4:0] rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // expected op and immediate from the RISC-V field layout
    task automatic ref_decode(input logic [31:0] w, output op_e op,
                              output logic [XLEN-1:0] imm);
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [XLEN-1:0] i_imm;
        f3    = w[14:12];
        f7    = w[31:25];
        i_imm = {{52{w[31]}}, w[31:20]};
        op    = OP_ILLEGAL;
        imm   = '0;
        case (w[6:0])
            7'b0000011: begin
                op  = load_op[f3];
                imm = i_imm;
            end
            7'b0100011: begin
                op  = store_op[f3];
                imm = {{52{w[31]}}, w[31:25], w[11:7]};
            end
            7'b0010011: begin
                op  = (f3 == 3'd5 && w[30]) ? OP_SRAI : imm_op[f3];
                imm = (f3 == 3'd1 || f3 == 3'd5) ? {58'b0, w[25:20]} : i_imm;  // shamt
            end
            7'b0110011: begin
                op = (f7 == 7'h01) ? mul_op[f3] : reg_op[f3];
                if (f7 == 7'h20) begin
                    op = (f3 == 3'd0) ? OP_SUB : (f3 == 3'd5) ? OP_SRA : OP_ILLEGAL;
                end
            end
            7'b0111011: begin
                op = (f7 == 7'h01) ? mulw_op[f3] : regw_op[f3];
                if (f7 == 7'h20) begin
                    op = (f3 == 3'd0) ? OP_SUBW : (f3 == 3'd5) ? OP_SRAW : OP_ILLEGAL;
                end
            end
            7'b0110111: begin
                op  = OP_LUI;
                imm = {{32{w[31]}}, w[31:12], 12'b0};
            end
            7'b0010111: begin
                op  = OP_AUIPC;
                imm = {{32{w[31]}}, w[31:12], 12'b0};
            end
            7'b1101111: begin
                op  = OP_JAL;
                imm = {{44{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1110011: begin
                if (w == 32'h0000_0073 || w == 32'h0010_0073 || w == 32'h3020_0073) begin
                    op = (w[29]) ? OP_MRET : (w[20]) ? OP_EBREAK : OP_ECALL;
                end else if (f3 == 3'd1 || f3 == 3'd2) begin
                    op  = (f3 == 3'd1) ? OP_CSRRW : OP_CSRRS;
                    imm = i_imm;                  // csr address
                end
            end
            default: op = OP_ILLEGAL;
        endcase
        if (op == OP_ILLEGAL) begin
            imm = '0;
        end
    endtask

    task automatic compare_field(string field, logic [63:0] exp, logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        err_start = errors;
        for (int i = 0; i < 1024; i++) begin
            prog[i] = enc_i(12'(i), 5'(i >> 5), 3'd0, 5'(i), 7'b0010011);  // addi per address
        end
    endtask

    task automatic end_test();
        if (errors == err_start) begin
            n_pass++;
            $display("PASS %s", test_name);
        end else begin
            n_fail++;
            $display("FAIL %s with %0d failed checks", test_name, errors - err_start);
        end
    endtask

    task automatic expect_linear(int n);
        exp_idx.delete();
        for (int i = 0; i < n; i++) begin
            exp_idx.push_back(i);
        end
    endtask

    // reset the DUT, load the program, then record until enough records arrive
    task automatic run_program();
        rst        <= 1'b1;
        collecting = 1'b0;
        repeat (16) @(posedge clk);
        mem = prog;
        got_pc.delete();
        got_op.delete();
        got_rd.delete();
        got_rs1.delete();
        got_rs2.delete();
        got_imm.delete();
        rst        <= 1'b0;
        collecting = 1'b1;
        while (got_pc.size() < exp_idx.size()) begin
            @(posedge clk);
        end
        collecting = 1'b0;
    endtask

    task automatic check_records();
        logic [ILEN-1:0] w;
        op_e             op;
        logic [XLEN-1:0] imm;
        for (int i = 0; i < exp_idx.size(); i++) begin
            w = mem[exp_idx[i]];
            ref_decode(w, op, imm);
            compare_field("pc", RESET_PC + 64'(4 * exp_idx[i]), got_pc[i]);
            compare_field("op", 64'(op), 64'(got_op[i]));
            compare_field("rd", 64'(w[11:7]), 64'(got_rd[i]));
            compare_field("rs1", 64'(w[19:15]), 64'(got_rs1[i]));
            compare_field("rs2", 64'(w[24:20]), 64'(got_rs2[i]));
            compare_field("imm", imm, got_imm[i]);
        end
    endtask

    task automatic test_reset();
        begin_test("reset");
        mem = prog;
        repeat (15) begin
            @(negedge clk);
            compare_field("dec_valid", 64'(1'b0), 64'(dec_valid));
            compare_field("mem_req", 64'(1'b0), 64'(mem_req));
        end
        @(posedge clk);
        rst <= 1'b0;                          // 16th reset edge
        @(negedge clk);
        compare_field("dec_valid", 64'(1'b0), 64'(dec_valid));
        compare_field("mem_req", 64'(1'b0), 64'(mem_req));
        while (!mem_req) begin
            @(negedge clk);
        end
        compare_field("mem_addr", RESET_PC, mem_addr);
        @(posedge clk);                       // next test drives from a rising edge
        end_test();
    endtask

    task automatic test_field_decode();
        begin_test("field decode");
        prog[0] = enc_i(12'hFEF, 5'd6, 3'd0, 5'd5, 7'b0010011);      // addi -17
        prog[1] = enc_r(7'h00, 5'd9, 5'd8, 3'd0, 5'd7, 7'b0110011);
        prog[2] = enc_r(7'h20, 5'd12, 5'd11, 3'd0, 5'd10, 7'b0110011);
        prog[3] = enc_s(12'hFDC, 5'd13, 5'd14, 3'd2);                  // sw -36
        prog[4] = {20'hABCDE, 5'd15, 7'b0110111};
        prog[5] = {20'h12345, 5'd16, 7'b0010111};
        prog[6] = enc_i({6'b010000, 6'd45}, 5'd18, 3'd5, 5'd17, 7'b0010011);
        prog[7] = enc_r(7'h01, 5'd21, 5'd20, 3'd0, 5'd19, 7'b0111011);
        prog[8] = enc_i(12'hFF8, 5'd23, 3'd3, 5'd22, 7'b0000011);      // ld -8
        expect_linear(9);
        run_program();
        check_records();
        end_test();
    endtask

    task automatic test_jump();
        begin_test("jump redirect");
        prog[1] = enc_j(21'd16, 5'd1);          // forward to word 5
        prog[6] = enc_j(21'h1F_FFE8, 5'd0);     // back to word 0
        exp_idx = '{0, 1, 5, 6, 0, 1, 5, 6};
        run_program();
        check_records();
        end_test();
    endtask

    task automatic test_backpressure();
        begin_test("back-pressure");
        stall_en = 1'b1;
        expect_linear(32);
        run_program();
        stall_en = 1'b0;
        check_records();
        end_test();
    endtask

    task automatic test_system();
        begin_test("system and illegal");
        prog[0] = 32'h0000_0073;
        prog[1] = 32'h0010_0073;
        prog[2] = 32'h3020_0073;
        prog[3] = enc_i(12'h305, 5'd2, 3'd1, 5'd1, 7'b1110011);       // csrrw mtvec
        prog[4] = enc_i(12'h300, 5'd0, 3'd2, 5'd3, 7'b1110011);       // csrrs mstatus
        prog[5] = 32'h0000_0000;
        prog[6] = 32'h0000_000B;                 // custom-0 major opcode
        expect_linear(7);
        run_program();
        check_records();
        end_test();
    endtask

    initial begin
        rst        = 1'b1;
        dec_ready  = 1'b0;
        mem_ack    = 1'b0;
        mem_rdata  = '0;
        stall_en   = 1'b0;
        stall_cnt  = 0;
        collecting = 1'b0;
        errors     = 0;
        n_pass     = 0;
        n_fail     = 0;
        cycles     = 0;
        void'($urandom(32'h8878));
        test_reset();
        test_field_decode();
        test_jump();
        test_backpressure();
        test_system();
        $display("%0d tests passed, %0d failed, %0d failed checks", n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
